// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = tb_rob_top
FLIST      = flist.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/rob_tests.txt ====
// kind mask | lane0: prd we pfree opc | lane1: prd we pfree opc | writeback seq0 seq1
// kind 00 idle, 01 push, 02 writeback, 03 flush, 04 stall (mask bit 0), ff end of list
01 03 0a 01 20 00 0b 01 21 02 00 00
01 01 0c 00 22 01 00 00 00 00 00 00
01 03 0d 01 23 02 0e 01 24 03 00 00
02 01 00 00 00 00 00 00 00 00 02 00
02 03 00 00 00 00 00 00 00 00 01 04
00 00 00 00 00 00 00 00 00 00 00 00
02 01 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00
02 01 00 00 00 00 00 00 00 00 03 00
00 00 00 00 00 00 00 00 00 00 00 00
04 01 00 00 00 00 00 00 00 00 00 00
01 03 10 01 25 00 11 00 26 01 00 00
01 03 12 01 27 02 13 01 28 03 00 00
01 03 14 00 29 03 15 01 2a 00 00 00
01 03 16 01 2b 01 17 01 2c 02 00 00
02 03 00 00 00 00 00 00 00 00 05 06
00 00 00 00 00 00 00 00 00 00 00 00
04 00 00 00 00 00 00 00 00 00 00 00
01 03 18 01 2d 00 19 00 2e 01 00 00
03 00 00 00 00 00 00 00 00 00 00 00
01 01 1a 01 2f 02 00 00 00 00 00 00
ff 00 00 00 00 00 00 00 00 00 00 00

// ==== bench/tb_rob_top.sv ====
// Stimulus file is written for two banks of four entries; run from the project root
`timescale 1ns/10ps

module tb_rob_top
   import rob_cfg_pkg::*, rob_entry_pkg::*;
;

   localparam int P_COMMIT_WIDTH = 1;
   localparam int P_ROB_DEPTH    = 2;
   localparam int BANKS   = 1 << P_COMMIT_WIDTH;
   localparam int DEPTH   = 1 << P_ROB_DEPTH;
   localparam int REC_W   = 2 + 5 * BANKS;
   localparam int MAX_REC = 64;

   // Record kinds
   localparam logic [7:0] K_IDLE  = 8'h00;
   localparam logic [7:0] K_PUSH  = 8'h01;
   localparam logic [7:0] K_WB    = 8'h02;
   localparam logic [7:0] K_FLUSH = 8'h03;
   localparam logic [7:0] K_STALL = 8'h04;
   localparam logic [7:0] K_END   = 8'hff;

   logic                                 clk = 1'b0;
   logic                                 rst_n, flush, retire_stall, rob_ready;
   logic [P_COMMIT_WIDTH:0]              push_size;
   opc_class_t [BANKS-1:0]               push_opc, cmt_opc;
   logic [BANKS-1:0][PC_W-1:0]           push_pc, cmt_pc;
   logic [BANKS-1:0][PRF_AW-1:0]         push_prd, push_pfree, cmt_prd, cmt_pfree;
   logic [BANKS-1:0]                     push_prd_we, wb_comp, cmt_valid, cmt_prd_we;
   logic [BANKS-1:0][P_ROB_DEPTH-1:0]    rob_free_id, wb_rob_id;
   logic [BANKS-1:0][P_COMMIT_WIDTH-1:0] rob_free_bank, wb_rob_bank;

   logic [7:0]                 tests [MAX_REC*REC_W];
   int                         n_rec, errors, cycle_cnt;
   int                         limit = 100;
   integer                     seed = 32'h4ac83c98;
   // Reference model, indexed by program-order sequence number since the last flush
   int                         n_push, ret_ptr, tail;
   int                         wcnt [BANKS];
   int                         occ [BANKS];
   int                         m_bank [256];
   int                         m_id [256];
   rob_entry_t                 m_entry [256];
   bit                         m_done [256];
   logic [BANKS-1:0][PC_W-1:0] lane_pc;

   rob_top #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH),
      .P_ROB_DEPTH    (P_ROB_DEPTH)
   ) i_rob_top (
      .clk (clk), .rst_n (rst_n), .flush (flush),
      .push_size (push_size), .push_opc (push_opc), .push_pc (push_pc),
      .push_prd (push_prd), .push_prd_we (push_prd_we), .push_pfree (push_pfree),
      .rob_ready (rob_ready), .rob_free_id (rob_free_id), .rob_free_bank (rob_free_bank),
      .wb_comp (wb_comp), .wb_rob_bank (wb_rob_bank), .wb_rob_id (wb_rob_id),
      .retire_stall (retire_stall), .cmt_valid (cmt_valid), .cmt_opc (cmt_opc),
      .cmt_pc (cmt_pc), .cmt_prd (cmt_prd), .cmt_prd_we (cmt_prd_we), .cmt_pfree (cmt_pfree)
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= limit)
      begin
         $display("Timeout: the test records did not complete within %0d cycles", limit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   // Every bank must have a free slot for a whole group
   function automatic bit model_ready();
      bit rdy;
      rdy = 1'b1;
      for (int b = 0; b < BANKS; b++)
         if (occ[b] >= DEPTH)
            rdy = 1'b0;
      return rdy;
   endfunction

   task automatic check_outputs(output int n_ret);
      logic [BANKS-1:0] exp_valid;
      bit               run;
      int               s;
      int               b;
      n_ret     = 0;
      run       = 1'b1;
      exp_valid = '0;
      // Oldest entries retire while they are done, in order
      for (int k = 0; k < BANKS; k++)
      begin
         s = ret_ptr + k;
         if (run && !retire_stall && s < n_push && m_done[s])
         begin
            exp_valid[k] = 1'b1;
            n_ret++;
         end
         else
            run = 1'b0;
      end
      compare_field("cmt_valid", cmt_valid, exp_valid);
      compare_field("rob_ready", rob_ready, model_ready());
      for (int k = 0; k < n_ret; k++)
      begin
         s = ret_ptr + k;
         compare_field($sformatf("cmt_opc[%0d]", k), cmt_opc[k], m_entry[s].opc);
         compare_field($sformatf("cmt_pc[%0d]", k), cmt_pc[k], m_entry[s].pc);
         compare_field($sformatf("cmt_prd[%0d]", k), cmt_prd[k], m_entry[s].prd);
         compare_field($sformatf("cmt_prd_we[%0d]", k), cmt_prd_we[k], m_entry[s].prd_we);
         compare_field($sformatf("cmt_pfree[%0d]", k), cmt_pfree[k], m_entry[s].pfree);
      end
      for (int k = 0; k < BANKS; k++)
      begin
         b = (tail + k) % BANKS;
         compare_field($sformatf("rob_free_bank[%0d]", k), rob_free_bank[k], b);
         compare_field($sformatf("rob_free_id[%0d]", k), rob_free_id[k], wcnt[b] % DEPTH);
      end
   endtask

   task automatic update_model(input logic [7:0] kind, input int base, input int lanes,
                               input int n_ret);
      int b;
      int o;
      if (kind == K_FLUSH)
      begin
         n_push  = 0;
         ret_ptr = 0;
         tail    = 0;
         for (int i = 0; i < BANKS; i++)
         begin
            wcnt[i] = 0;
            occ[i]  = 0;
         end
      end
      else
      begin
         for (int i = 0; i < n_ret; i++)
         begin
            occ[m_bank[ret_ptr]]--;
            ret_ptr++;
         end
         // Lane k lands on bank tail + k at that bank's write count
         for (int k = 0; k < lanes; k++)
         begin
            b = tail;
            o = base + 2 + 4 * k;
            m_bank[n_push]  = b;
            m_id[n_push]    = wcnt[b] % DEPTH;
            m_entry[n_push] = '{opc: opc_class_t'(tests[o+3][1:0]), pc: lane_pc[k],
                                prd: tests[o][PRF_AW-1:0], prd_we: tests[o+1][0],
                                pfree: tests[o+2][PRF_AW-1:0]};
            m_done[n_push]  = 1'b0;
            wcnt[b]++;
            occ[b]++;
            tail = (tail + 1) % BANKS;
            n_push++;
         end
         if (kind == K_WB)
            for (int k = 0; k < BANKS; k++)
               if (tests[base+1][k])
                  m_done[tests[base+2+4*BANKS+k]] = 1'b1;
      end
   endtask

   task automatic run_cycle(input logic [7:0] kind, input int base);
      int n_ret;
      int lanes;
      int s;
      lanes = 0;
      @(posedge clk);
      flush     <= (kind == K_FLUSH);
      push_size <= '0;
      wb_comp   <= '0;
      if (kind == K_STALL)
         retire_stall <= tests[base+1][0];
      if (kind == K_PUSH)
      begin
         for (int k = 0; k < BANKS; k++)
         begin
            if (tests[base+1][k])
               lanes++;
            lane_pc[k] = $random(seed);
            push_pc[k]     <= lane_pc[k];
            push_prd[k]    <= tests[base+2+4*k][PRF_AW-1:0];
            push_prd_we[k] <= tests[base+3+4*k][0];
            push_pfree[k]  <= tests[base+4+4*k][PRF_AW-1:0];
            push_opc[k]    <= opc_class_t'(tests[base+5+4*k][1:0]);
         end
         push_size <= (P_COMMIT_WIDTH+1)'(lanes);
      end
      if (kind == K_WB)
         for (int k = 0; k < BANKS; k++)
            if (tests[base+1][k])
            begin
               s = tests[base+2+4*BANKS+k];
               assert (s >= ret_ptr && s < n_push)
               else
               begin
                  errors++;
                  $display("Writeback names sequence number %0d, which is not in flight", s);
               end
               wb_comp[k]     <= 1'b1;
               wb_rob_bank[k] <= m_bank[s];
               wb_rob_id[k]   <= m_id[s];
            end
      @(negedge clk);
      check_outputs(n_ret);
      update_model(kind, base, lanes, n_ret);
   endtask

   initial
   begin
      int base;
      rst_n        = 1'b0;
      flush        = 1'b0;
      retire_stall = 1'b0;
      push_size    = '0;
      for (int k = 0; k < BANKS; k++)
         push_opc[k] = opc_alu;
      push_pc      = '0;
      push_prd     = '0;
      push_prd_we  = '0;
      push_pfree   = '0;
      wb_comp      = '0;
      wb_rob_bank  = '0;
      wb_rob_id    = '0;
      $readmemh("bench/rob_tests.txt", tests);
      n_rec = 0;
      while (n_rec < MAX_REC && tests[n_rec*REC_W] !== K_END)
         n_rec++;
      limit = 20 * n_rec + 100;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      for (int r = 0; r < n_rec; r++)
      begin
         base = r * REC_W;
         // Hold a push until every bank has room
         while (tests[base] == K_PUSH && !model_ready())
            run_cycle(K_IDLE, base);
         run_cycle(tests[base], base);
      end
      run_cycle(K_IDLE, 0);
      $display("Records run: %0d, errors: %0d", n_rec, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
hdl/rob_cfg_pkg.sv
hdl/rob_entry_pkg.sv
hdl/fifo_fwft_ctrl.sv
hdl/rob_payload_ram.sv
hdl/rob_cmplt_table.sv
hdl/rob.sv
hdl/rob_commit.sv
hdl/rob_top.sv
bench/tb_rob_top.sv

// ==== hdl/fifo_fwft_ctrl.sv ====
// Depth is a power of two; push when full and pop when empty are ignored, no data path here
`timescale 1ns/10ps

module fifo_fwft_ctrl
#(
   parameter int DW          = 1,
   parameter int DEPTH_WIDTH = 3
)
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   flush,
   input  logic                   push,
   input  logic                   pop,
   output logic                   ready,
   output logic                   valid,
   output logic [DEPTH_WIDTH-1:0] payload_waddr,
   output logic [DEPTH_WIDTH-1:0] payload_raddr,
   output logic                   payload_we
);

   localparam logic [DEPTH_WIDTH:0] FULL_CNT = 1 << DEPTH_WIDTH;
   // A zero-width payload only counts tokens
   localparam logic HAS_PAYLOAD = (DW > 0);

   logic [DEPTH_WIDTH-1:0] w_idx, r_idx;
   logic [DEPTH_WIDTH:0]   count;
   logic                   do_push, do_pop;

   assign ready   = (count != FULL_CNT);
   assign valid   = (count != '0);
   assign do_push = push & ready;
   assign do_pop  = pop & valid;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         w_idx <= '0;
         r_idx <= '0;
         count <= '0;
      end
      else if (flush)
      begin
         w_idx <= '0;
         r_idx <= '0;
         count <= '0;
      end
      else
      begin
         if (do_push)
            w_idx <= w_idx + 1'b1;
         if (do_pop)
            r_idx <= r_idx + 1'b1;
         // Simultaneous push and pop keeps the count
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Next write slot doubles as the allocation id
   assign payload_waddr = w_idx;
   assign payload_raddr = r_idx;
   assign payload_we    = do_push & HAS_PAYLOAD;

endmodule

// ==== hdl/rob.sv ====
// Issue side must push only while rob_ready is high; pop_size must not exceed valid head lanes
`timescale 1ns/10ps

module rob
   import rob_cfg_pkg::*, rob_entry_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = 1,
   parameter int P_ROB_DEPTH    = 3
)
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      flush,
   input  logic [P_COMMIT_WIDTH:0]                   push_size,
   input  opc_class_t [rob_banks(P_COMMIT_WIDTH)-1:0] push_opc,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][PC_W-1:0]   push_pc,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] push_prd,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0]      push_prd_we,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] push_pfree,
   input  logic [P_COMMIT_WIDTH:0]                   pop_size,
   output logic                                      rob_ready,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH-1:0]    rob_free_id,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_COMMIT_WIDTH-1:0] rob_free_bank,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0]      alloc_we,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0]      head_valid,
   output rob_entry_t [rob_banks(P_COMMIT_WIDTH)-1:0] head_entry,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH-1:0]    head_id,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_COMMIT_WIDTH-1:0] head_bank
);

   localparam int BANKS = rob_banks(P_COMMIT_WIDTH);

   logic [P_COMMIT_WIDTH-1:0]                head_q, tail_q;
   rob_entry_t [BANKS-1:0]                   lane_entry;
   rob_entry_t [BANKS-1:0]                   bank_wdata, bank_rdata;
   logic [BANKS-1:0]                         bank_push, bank_pop;
   logic [BANKS-1:0]                         bank_ready, bank_valid, bank_we;
   logic [BANKS-1:0][P_ROB_DEPTH-1:0]        bank_waddr, bank_raddr;

   // Both pointers wrap modulo BANKS
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head_q <= '0;
         tail_q <= '0;
      end
      else if (flush)
      begin
         head_q <= '0;
         tail_q <= '0;
      end
      else
      begin
         head_q <= head_q + pop_size[P_COMMIT_WIDTH-1:0];
         tail_q <= tail_q + push_size[P_COMMIT_WIDTH-1:0];
      end
   end

   for (genvar k = 0; k < BANKS; k++)
   begin : g_lane
      assign lane_entry[k] = '{opc:    push_opc[k],
                               pc:     push_pc[k],
                               prd:    push_prd[k],
                               prd_we: push_prd_we[k],
                               pfree:  push_pfree[k]};
      assign alloc_we[k]      = (push_size > (P_COMMIT_WIDTH+1)'(k));
      assign rob_free_bank[k] = tail_q + P_COMMIT_WIDTH'(k);
      assign rob_free_id[k]   = bank_waddr[rob_free_bank[k]];
      // Head window lane k reads bank head + k
      assign head_bank[k]  = head_q + P_COMMIT_WIDTH'(k);
      assign head_valid[k] = bank_valid[head_bank[k]];
      assign head_entry[k] = bank_rdata[head_bank[k]];
      assign head_id[k]    = bank_raddr[head_bank[k]];
   end

   for (genvar b = 0; b < BANKS; b++)
   begin : g_bank
      logic [P_COMMIT_WIDTH-1:0] tail_off, head_off;

      // Lane that lands on this bank, and its place in the pop group
      assign tail_off      = P_COMMIT_WIDTH'(b) - tail_q;
      assign head_off      = P_COMMIT_WIDTH'(b) - head_q;
      assign bank_wdata[b] = lane_entry[tail_off];
      assign bank_push[b]  = ({1'b0, tail_off} < push_size);
      assign bank_pop[b]   = ({1'b0, head_off} < pop_size);

      fifo_fwft_ctrl #(
         .DW          ($bits(rob_entry_t)),
         .DEPTH_WIDTH (P_ROB_DEPTH)
      ) u_fifo (
         .clk           (clk),
         .rst_n         (rst_n),
         .flush         (flush),
         .push          (bank_push[b]),
         .pop           (bank_pop[b]),
         .ready         (bank_ready[b]),
         .valid         (bank_valid[b]),
         .payload_waddr (bank_waddr[b]),
         .payload_raddr (bank_raddr[b]),
         .payload_we    (bank_we[b])
      );

      rob_payload_ram #(
         .P_ROB_DEPTH (P_ROB_DEPTH)
      ) u_ram (
         .clk   (clk),
         .we    (bank_we[b]),
         .waddr (bank_waddr[b]),
         .wdata (bank_wdata[b]),
         .raddr (bank_raddr[b]),
         .rdata (bank_rdata[b])
      );
   end

   // A full group fits only if every bank has room
   assign rob_ready = &bank_ready;

endmodule

// ==== hdl/rob_cfg_pkg.sv ====
// Bank count must be a power of two; banks and depth are given as log2 values
package rob_cfg_pkg;

   // log2 of the bank count, which is also the issue and commit width
   localparam int P_COMMIT_WIDTH_DEF = 1;

   // log2 of the entries held per bank
   localparam int P_ROB_DEPTH_DEF = 3;

   localparam int PC_W = 32;

   // Banks from the log2 commit width
   function automatic int rob_banks(input int p_commit_width);
      return 1 << p_commit_width;
   endfunction

   // Total entries in flight over all banks
   function automatic int rob_entries(input int p_commit_width, input int p_rob_depth);
      return rob_banks(p_commit_width) << p_rob_depth;
   endfunction

endpackage

// ==== hdl/rob_cmplt_table.sv ====
// Writeback to an unallocated id is illegal and not detected; flush clears every done bit
`timescale 1ns/10ps

module rob_cmplt_table
   import rob_cfg_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = 1,
   parameter int P_ROB_DEPTH    = 3
)
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      flush,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0]      alloc_we,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_COMMIT_WIDTH-1:0] alloc_bank,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH-1:0]    alloc_id,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0]      wb_comp,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_COMMIT_WIDTH-1:0] wb_rob_bank,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH-1:0]    wb_rob_id,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_COMMIT_WIDTH-1:0] head_bank,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH-1:0]    head_id,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0]      head_done
);

   localparam int BANKS   = rob_banks(P_COMMIT_WIDTH);
   localparam int ENTRIES = rob_entries(P_COMMIT_WIDTH, P_ROB_DEPTH);

   // Entry {bank, id} sits at bit bank*depth + id
   logic [ENTRIES-1:0] done_q, done_nxt;

   always_comb
   begin
      done_nxt = done_q;
      for (int k = 0; k < BANKS; k++)
         if (alloc_we[k])
            done_nxt[{alloc_bank[k], alloc_id[k]}] = 1'b0;
      for (int k = 0; k < BANKS; k++)
         if (wb_comp[k])
            done_nxt[{wb_rob_bank[k], wb_rob_id[k]}] = 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         done_q <= '0;
      else if (flush)
         done_q <= '0;
      else
         done_q <= done_nxt;
   end

   for (genvar k = 0; k < BANKS; k++)
   begin : g_head
      assign head_done[k] = done_q[{head_bank[k], head_id[k]}];
   end

endmodule

// ==== hdl/rob_commit.sv ====
// Retires only a contiguous run of done entries from the head; nothing retires under stall
`timescale 1ns/10ps

module rob_commit
   import rob_cfg_pkg::*, rob_entry_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = 1
)
(
   input  logic                                      retire_stall,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0]      head_valid,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0]      head_done,
   input  rob_entry_t [rob_banks(P_COMMIT_WIDTH)-1:0] head_entry,
   output logic [P_COMMIT_WIDTH:0]                   pop_size,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0]      cmt_valid,
   output opc_class_t [rob_banks(P_COMMIT_WIDTH)-1:0] cmt_opc,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][PC_W-1:0]   cmt_pc,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] cmt_prd,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0]      cmt_prd_we,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] cmt_pfree
);

   localparam int BANKS = rob_banks(P_COMMIT_WIDTH);

   logic [BANKS-1:0] lane_rdy, lane_ok;

   assign lane_rdy = head_valid & head_done & {BANKS{~retire_stall}};

   // First lane not ready masks all younger lanes
   always_comb
   begin
      lane_ok    = '0;
      pop_size   = '0;
      lane_ok[0] = lane_rdy[0];
      for (int k = 1; k < BANKS; k++)
         lane_ok[k] = lane_ok[k-1] & lane_rdy[k];
      for (int k = 0; k < BANKS; k++)
         pop_size = pop_size + (P_COMMIT_WIDTH+1)'(lane_ok[k]);
   end

   assign cmt_valid = lane_ok;

   for (genvar k = 0; k < BANKS; k++)
   begin : g_unpack
      assign cmt_opc[k]    = head_entry[k].opc;
      assign cmt_pc[k]     = head_entry[k].pc;
      assign cmt_prd[k]    = head_entry[k].prd;
      assign cmt_prd_we[k] = head_entry[k].prd_we;
      assign cmt_pfree[k]  = head_entry[k].pfree;
   end

endmodule

// ==== hdl/rob_entry_pkg.sv ====
// Operand buses are reduced to a 2-bit opcode class; entry layout is fixed at 47 bits
package rob_entry_pkg;
   import rob_cfg_pkg::*;

   // Physical register address width
   localparam int PRF_AW = 6;

   // Execution unit that owns the instruction
   typedef enum logic [1:0]
   {
      opc_alu = 2'd0,
      opc_bru = 2'd1,
      opc_lsu = 2'd2,
      opc_epu = 2'd3
   } opc_class_t;

   // One buffer entry, MSB first
   typedef struct packed
   {
      opc_class_t          opc;
      logic [PC_W-1:0]     pc;
      logic [PRF_AW-1:0]   prd;
      logic                prd_we;
      // Register returned to the free list at retirement
      logic [PRF_AW-1:0]   pfree;
   } rob_entry_t;

endpackage

// ==== hdl/rob_payload_ram.sv ====
// Register array, no reset; read is combinational so the head entry shows without a cycle
`timescale 1ns/10ps

module rob_payload_ram
   import rob_entry_pkg::*;
#(
   parameter int P_ROB_DEPTH = 3
)
(
   input  logic                   clk,
   input  logic                   we,
   input  logic [P_ROB_DEPTH-1:0] waddr,
   input  rob_entry_t             wdata,
   input  logic [P_ROB_DEPTH-1:0] raddr,
   output rob_entry_t             rdata
);

   localparam int DEPTH = 1 << P_ROB_DEPTH;

   rob_entry_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we)
         mem[waddr] <= wdata;
   end

   // Fall-through view of the slot at the read index
   assign rdata = mem[raddr];

endmodule

// ==== hdl/rob_top.sv ====
// Allocation ids are the free ids shown to issue; writebacks must name allocated entries only
`timescale 1ns/10ps

module rob_top
   import rob_cfg_pkg::*, rob_entry_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = P_COMMIT_WIDTH_DEF,
   parameter int P_ROB_DEPTH    = P_ROB_DEPTH_DEF
)
(
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      flush,
   input  logic [P_COMMIT_WIDTH:0]                   push_size,
   input  opc_class_t [rob_banks(P_COMMIT_WIDTH)-1:0] push_opc,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][PC_W-1:0]   push_pc,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] push_prd,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0]      push_prd_we,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] push_pfree,
   output logic                                      rob_ready,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH-1:0]    rob_free_id,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_COMMIT_WIDTH-1:0] rob_free_bank,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0]      wb_comp,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_COMMIT_WIDTH-1:0] wb_rob_bank,
   input  logic [rob_banks(P_COMMIT_WIDTH)-1:0][P_ROB_DEPTH-1:0]    wb_rob_id,
   input  logic                                      retire_stall,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0]      cmt_valid,
   output opc_class_t [rob_banks(P_COMMIT_WIDTH)-1:0] cmt_opc,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][PC_W-1:0]   cmt_pc,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] cmt_prd,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0]      cmt_prd_we,
   output logic [rob_banks(P_COMMIT_WIDTH)-1:0][PRF_AW-1:0] cmt_pfree
);

   localparam int BANKS = rob_banks(P_COMMIT_WIDTH);

   logic [P_COMMIT_WIDTH:0]                  pop_size;
   logic [BANKS-1:0]                         alloc_we;
   logic [BANKS-1:0]                         head_valid, head_done;
   rob_entry_t [BANKS-1:0]                   head_entry;
   logic [BANKS-1:0][P_ROB_DEPTH-1:0]        head_id;
   logic [BANKS-1:0][P_COMMIT_WIDTH-1:0]     head_bank;

   rob #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH),
      .P_ROB_DEPTH    (P_ROB_DEPTH)
   ) u_rob (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .push_size     (push_size),
      .push_opc      (push_opc),
      .push_pc       (push_pc),
      .push_prd      (push_prd),
      .push_prd_we   (push_prd_we),
      .push_pfree    (push_pfree),
      .pop_size      (pop_size),
      .rob_ready     (rob_ready),
      .rob_free_id   (rob_free_id),
      .rob_free_bank (rob_free_bank),
      .alloc_we      (alloc_we),
      .head_valid    (head_valid),
      .head_entry    (head_entry),
      .head_id       (head_id),
      .head_bank     (head_bank)
   );

   // Pushed lanes take the ids that were offered to issue
   rob_cmplt_table #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH),
      .P_ROB_DEPTH    (P_ROB_DEPTH)
   ) u_cmplt (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .alloc_we    (alloc_we),
      .alloc_bank  (rob_free_bank),
      .alloc_id    (rob_free_id),
      .wb_comp     (wb_comp),
      .wb_rob_bank (wb_rob_bank),
      .wb_rob_id   (wb_rob_id),
      .head_bank   (head_bank),
      .head_id     (head_id),
      .head_done   (head_done)
   );

   rob_commit #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH)
   ) u_commit (
      .retire_stall (retire_stall),
      .head_valid   (head_valid),
      .head_done    (head_done),
      .head_entry   (head_entry),
      .pop_size     (pop_size),
      .cmt_valid    (cmt_valid),
      .cmt_opc      (cmt_opc),
      .cmt_pc       (cmt_pc),
      .cmt_prd      (cmt_prd),
      .cmt_prd_we   (cmt_prd_we),
      .cmt_pfree    (cmt_pfree)
   );

endmodule
